// ==== verilog/eye_tracker_cfg.svh ====
// Design-wide widths and result record constants
`ifndef EYE_TRACKER_CFG_SVH
`define EYE_TRACKER_CFG_SVH

// ------------------------------
// Camera side
// ------------------------------

// One Camera Link tap
`define PIXEL_WIDTH 8

// Pixel x and y positions up to 1024
`define COORD_WIDTH 10

// ------------------------------
// Centroid accumulators
// ------------------------------

`define SUM_S_WIDTH 20
`define SUM_SX_WIDTH 28
`define SUM_SY_WIDTH 28

// ------------------------------
// Result record
// ------------------------------

// Start-of-record marker byte
`define RECORD_MARK 8'hA5

// Marker, sequence, 3 count bytes, 4 x-sum bytes, 4 y-sum bytes
`define RECORD_BYTES 13

`endif

// ==== verilog/cl_pkg.sv ====
// Camera-side pixel and coordinate types
`default_nettype none

`include "eye_tracker_cfg.svh"

package cl_pkg;

    // One tap value from the camera
    typedef logic [`PIXEL_WIDTH-1:0] pixel_t;

    // Pixel column or line number
    typedef logic [`COORD_WIDTH-1:0] coord_t;

endpackage

`default_nettype wire

// ==== verilog/track_pkg.sv ====
// Accumulator, frame result and output record types
`default_nettype none

`include "eye_tracker_cfg.svh"

package track_pkg;

    // Per-frame accumulators
    typedef logic [`SUM_S_WIDTH-1:0]  sum_s_t;
    typedef logic [`SUM_SX_WIDTH-1:0] sum_sx_t;
    typedef logic [`SUM_SY_WIDTH-1:0] sum_sy_t;

    // Dark pixel count and coordinate sums of one frame
    typedef struct packed {
        sum_s_t  sum_s;
        sum_sx_t sum_sx;
        sum_sy_t sum_sy;
    } frame_sums_t;

    typedef logic [7:0] byte_t;
    typedef logic [7:0] seq_t;

    // Whole record with the first byte in the top slot
    typedef logic [`RECORD_BYTES-1:0][7:0] record_t;

endpackage

`default_nettype wire

// ==== verilog/pix_stream_if.sv ====
// Decoded pixel beat stream interface with producer and consumer modports
`timescale 1ns/100ps
`default_nettype none

interface pix_stream_if;
    import cl_pkg::*;

    // One strobe per valid two-pixel beat
    logic   beat;
    // x of the left tap with the right tap at x+1
    coord_t x;
    coord_t y;
    pixel_t data_l;
    pixel_t data_r;
    // End of frame strobe that never comes with beat
    logic   eof;

    modport producer (
        output beat, x, y, data_l, data_r, eof
    );

    modport consumer (
        input beat, x, y, data_l, data_r, eof
    );

endinterface

`default_nettype wire

// ==== verilog/cl_frame_capture.sv ====
// Camera Link input registering, edge detection and pixel coordinate counters
`timescale 1ns/100ps
`default_nettype none

module cl_frame_capture (
    input  wire logic           cclk,
    input  wire logic           rst_n,
    input  wire logic           fval,
    input  wire logic           lval,
    input  wire logic           dval,
    input  wire cl_pkg::pixel_t data_l,
    input  wire cl_pkg::pixel_t data_r,
    pix_stream_if.producer      pix
);
    import cl_pkg::*;

    logic   fval_q;
    logic   lval_q;
    logic   dval_q;
    pixel_t data_l_q;
    pixel_t data_r_q;

    // Previous registered FVAL and LVAL for edge detection
    logic   fval_d;
    logic   lval_d;

    logic   fval_rise;
    logic   fval_fall;
    logic   lval_rise;
    logic   lval_fall;
    logic   beat_ok;

    coord_t x_cnt;
    coord_t y_cnt;
    coord_t x_cur;
    coord_t y_cur;

    // ------------------------------
    // Input registers
    // ------------------------------

    // DVAL is active low, so it idles high
    always_ff @(posedge cclk) begin
        if (!rst_n) begin
            fval_q <= 1'b0;
            lval_q <= 1'b0;
            dval_q <= 1'b1;
        end else begin
            fval_q <= fval;
            lval_q <= lval;
            dval_q <= dval;
        end
    end

    always_ff @(posedge cclk) begin
        data_l_q <= data_l;
        data_r_q <= data_r;
    end

    // ------------------------------
    // Edges and coordinates
    // ------------------------------

    assign fval_rise = fval_q & ~fval_d;
    assign fval_fall = ~fval_q & fval_d;
    assign lval_rise = lval_q & ~lval_d;
    assign lval_fall = ~lval_q & lval_d;
    assign beat_ok   = fval_q & lval_q & ~dval_q;

    // A beat on the very edge of a line or frame starts from zero
    assign x_cur = lval_rise ? '0 : x_cnt;
    assign y_cur = fval_rise ? '0 : y_cnt;

    always_ff @(posedge cclk) begin
        if (!rst_n) begin
            fval_d   <= 1'b0;
            lval_d   <= 1'b0;
            x_cnt    <= '0;
            y_cnt    <= '0;
            pix.beat <= 1'b0;
            pix.eof  <= 1'b0;
        end else begin
            fval_d   <= fval_q;
            lval_d   <= lval_q;
            pix.beat <= beat_ok;
            pix.eof  <= fval_fall;

            // Two pixels per beat
            if (beat_ok) begin
                x_cnt <= x_cur + coord_t'(2);
            end else if (lval_rise) begin
                x_cnt <= '0;
            end

            if (fval_rise) begin
                y_cnt <= '0;
            end else if (lval_fall && fval_q) begin
                y_cnt <= y_cnt + coord_t'(1);
            end
        end
    end

    always_ff @(posedge cclk) begin
        pix.x      <= x_cur;
        pix.y      <= y_cur;
        pix.data_l <= data_l_q;
        pix.data_r <= data_r_q;
    end

endmodule

`default_nettype wire

// ==== verilog/centroid_accum.sv ====
// Pixel thresholding and per-frame dark pixel count and coordinate sums
`timescale 1ns/100ps
`default_nettype none

`include "eye_tracker_cfg.svh"

module centroid_accum (
    input  wire logic              cclk,
    input  wire logic              rst_n,
    input  wire cl_pkg::pixel_t    threshold,
    pix_stream_if.consumer         pix,
    output logic                   result_valid,
    output track_pkg::frame_sums_t result
);
    import cl_pkg::*;
    import track_pkg::*;

    logic                  dark_l;
    logic                  dark_r;
    coord_t                x_r;

    // Per-beat increments
    logic [1:0]            add_s;
    logic [`COORD_WIDTH:0] add_sx;
    logic [`COORD_WIDTH:0] add_sy;

    sum_s_t                acc_s;
    sum_sx_t               acc_sx;
    sum_sy_t               acc_sy;

    // ------------------------------
    // Binarize both taps
    // ------------------------------

    // Pupil pixels are strictly darker than the threshold
    assign dark_l = pix.data_l < threshold;
    assign dark_r = pix.data_r < threshold;
    assign x_r    = pix.x + coord_t'(1);

    always_comb begin
        add_s  = {1'b0, dark_l} + {1'b0, dark_r};
        add_sx = {1'b0, (dark_l ? pix.x : coord_t'(0))}
               + {1'b0, (dark_r ? x_r : coord_t'(0))};
        // y counted once per dark pixel
        add_sy = {1'b0, (dark_l ? pix.y : coord_t'(0))}
               + {1'b0, (dark_r ? pix.y : coord_t'(0))};
    end

    // ------------------------------
    // Accumulate and hand over
    // ------------------------------

    // On eof the sums move to the result and the next frame starts from zero
    always_ff @(posedge cclk) begin
        if (!rst_n) begin
            acc_s        <= '0;
            acc_sx       <= '0;
            acc_sy       <= '0;
            result_valid <= 1'b0;
        end else begin
            result_valid <= pix.eof;
            if (pix.eof) begin
                acc_s  <= '0;
                acc_sx <= '0;
                acc_sy <= '0;
            end else if (pix.beat) begin
                acc_s  <= acc_s + sum_s_t'(add_s);
                acc_sx <= acc_sx + sum_sx_t'(add_sx);
                acc_sy <= acc_sy + sum_sy_t'(add_sy);
            end
        end
    end

    always_ff @(posedge cclk) begin
        if (pix.eof) begin
            result.sum_s  <= acc_s;
            result.sum_sx <= acc_sx;
            result.sum_sy <= acc_sy;
        end
    end

endmodule

`default_nettype wire

// ==== verilog/result_framer.sv ====
// Frame result to 13-byte record serializer with sequence counter
`timescale 1ns/100ps
`default_nettype none

`include "eye_tracker_cfg.svh"

module result_framer (
    input  wire logic                   cclk,
    input  wire logic                   rst_n,
    input  wire logic                   result_valid,
    input  wire track_pkg::frame_sums_t result,
    output logic                        tx_valid,
    output track_pkg::byte_t            tx_byte
);
    import track_pkg::*;

    localparam int CNT_W = $clog2(`RECORD_BYTES + 1);

    record_t          record_next;
    record_t          shreg;
    logic [CNT_W-1:0] cnt;
    seq_t             seq;
    logic             busy;

    // ------------------------------
    // Record layout
    // ------------------------------

    // Sums go out MSB first with the count padded to 3 bytes
    assign record_next = {
        byte_t'(`RECORD_MARK),
        seq,
        24'(result.sum_s),
        32'(result.sum_sx),
        32'(result.sum_sy)
    };

    // ------------------------------
    // Byte streaming
    // ------------------------------

    // Bytes left in the current record
    assign busy = cnt != '0;

    always_ff @(posedge cclk) begin
        if (!rst_n) begin
            cnt <= '0;
            seq <= '0;
        end else if (!busy) begin
            // Results arriving mid-record are lost and leave seq untouched
            if (result_valid) begin
                cnt <= CNT_W'(`RECORD_BYTES);
                seq <= seq + seq_t'(1);
            end
        end else begin
            cnt <= cnt - CNT_W'(1);
        end
    end

    always_ff @(posedge cclk) begin
        if (!busy && result_valid) begin
            shreg <= record_next;
        end else if (busy) begin
            shreg <= {shreg[`RECORD_BYTES-2:0], byte_t'(0)};
        end
    end

    assign tx_valid = busy;
    assign tx_byte  = shreg[`RECORD_BYTES-1];

endmodule

`default_nettype wire

// ==== verilog/eye_tracker_top.sv ====
// Eye tracker top level, camera input to result record output
`timescale 1ns/100ps
`default_nettype none

module eye_tracker_top (
    input  wire logic             cclk,
    input  wire logic             rst_n,
    // Camera Link with DVAL active low
    input  wire logic             fval,
    input  wire logic             lval,
    input  wire logic             dval,
    input  wire cl_pkg::pixel_t   data_l,
    input  wire cl_pkg::pixel_t   data_r,
    // Dark pixel threshold
    input  wire cl_pkg::pixel_t   threshold,
    // Result record bytes
    output wire logic             tx_valid,
    output wire track_pkg::byte_t tx_byte
);
    import track_pkg::*;

    logic        result_valid;
    frame_sums_t result;

    pix_stream_if pix ();

    cl_frame_capture u_capture (
        .cclk   (cclk),
        .rst_n  (rst_n),
        .fval   (fval),
        .lval   (lval),
        .dval   (dval),
        .data_l (data_l),
        .data_r (data_r),
        .pix    (pix.producer)
    );

    centroid_accum u_accum (
        .cclk         (cclk),
        .rst_n        (rst_n),
        .threshold    (threshold),
        .pix          (pix.consumer),
        .result_valid (result_valid),
        .result       (result)
    );

    result_framer u_framer (
        .cclk         (cclk),
        .rst_n        (rst_n),
        .result_valid (result_valid),
        .result       (result),
        .tx_valid     (tx_valid),
        .tx_byte      (tx_byte)
    );

endmodule

`default_nettype wire

// ==== verif/eye_tracker_asserts.sv ====
// Concurrent assertions on the record byte strobe, bound to the eye tracker top level
`timescale 1ns/100ps
`default_nettype none

`include "eye_tracker_cfg.svh"

module eye_tracker_asserts (
    input wire logic             cclk,
    input wire logic             rst_n,
    input wire logic             tx_valid,
    input wire track_pkg::byte_t tx_byte
);
    import track_pkg::*;

    logic [3:0] since_reset;
    // Consecutive high cycles of tx_valid before this one
    logic [4:0] run_len;

    always_ff @(posedge cclk) begin
        if (!rst_n) begin
            since_reset <= '0;
            run_len     <= '0;
        end else begin
            if (since_reset != 4'hF)
                since_reset <= since_reset + 4'd1;
            run_len <= tx_valid ? run_len + 5'd1 : 5'd0;
        end
    end

    a_quiet_after_reset: assert property (@(posedge cclk) disable iff (!rst_n)
        (since_reset < 4'd8) |-> !tx_valid)
        else $error("tx_valid high within 8 cycles of reset");

    a_record_length: assert property (@(posedge cclk) disable iff (!rst_n)
        tx_valid |-> (run_len < 5'(`RECORD_BYTES)))
        else $error("tx_valid high for more than one record");

    a_record_mark: assert property (@(posedge cclk) disable iff (!rst_n)
        $rose(tx_valid) |-> (tx_byte == byte_t'(`RECORD_MARK)))
        else $error("record does not start with the marker byte");

endmodule

bind eye_tracker_top eye_tracker_asserts u_asserts (
    .cclk     (cclk),
    .rst_n    (rst_n),
    .tx_valid (tx_valid),
    .tx_byte  (tx_byte)
);

`default_nettype wire

// ==== verif/tb_eye_tracker.sv ====
// Directed testbench for the eye tracker with frame driver, reference model and compare tasks
`timescale 1ns/100ps
`default_nettype none

`include "eye_tracker_cfg.svh"

module tb_eye_tracker;
    import cl_pkg::*;
    import track_pkg::*;

    localparam int MAX_W   = 16;
    localparam int MAX_H   = 8;
    localparam int NPIX    = MAX_W * MAX_H;
    localparam int TIMEOUT = 200;

    logic        cclk;
    logic        rst_n;
    logic        fval;
    logic        lval;
    logic        dval;
    pixel_t      data_l;
    pixel_t      data_r;
    pixel_t      threshold;
    logic        tx_valid;
    byte_t       tx_byte;

    // Frame image in row-major order with a fixed stride of MAX_W
    pixel_t      img [0:NPIX-1];
    byte_t       exp_rec [0:`RECORD_BYTES-1];
    byte_t       got_rec [0:`RECORD_BYTES-1];
    frame_sums_t exp_sums;
    seq_t        exp_seq;
    int unsigned lcg_state;
    int          value_errors;
    int          other_errors;
    int          cycle_cnt = 0;
    int          fall_cycle;

    eye_tracker_top DUT (
        .cclk      (cclk),
        .rst_n     (rst_n),
        .fval      (fval),
        .lval      (lval),
        .dval      (dval),
        .data_l    (data_l),
        .data_r    (data_r),
        .threshold (threshold),
        .tx_valid  (tx_valid),
        .tx_byte   (tx_byte)
    );

    initial begin
        cclk = 1'b0;
        forever #50 cclk = ~cclk;
    end

    always @(posedge cclk) cycle_cnt <= cycle_cnt + 1;

    function automatic int unsigned lcg_next();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return lcg_state >> 16;
    endfunction

    // ------------------------------
    // Stimulus
    // ------------------------------

    task automatic drive(input logic f, input logic l, input logic d,
                         input pixel_t a, input pixel_t b);
        @(posedge cclk);
        #10;
        fval   = f;
        lval   = l;
        dval   = d;
        data_l = a;
        data_r = b;
    endtask

    // Invalid beats carry dark data so that a leak would show in the sums
    task automatic send_frame(input pixel_t frame [0:NPIX-1], input int w, input int h,
                              input pixel_t thr, input bit gaps);
        drive(1'b0, 1'b0, 1'b1, 8'h00, 8'h00);
        threshold = thr;
        repeat (2) drive(1'b0, 1'b0, 1'b1, 8'h00, 8'h00);
        drive(1'b1, 1'b0, 1'b1, 8'h00, 8'h00);
        for (int y = 0; y < h; y++) begin
            for (int x = 0; x < w; x += 2) begin
                if (gaps && (x % 4 == 0))
                    drive(1'b1, 1'b1, 1'b1, 8'h00, 8'h00);
                drive(1'b1, 1'b1, 1'b0, frame[y*MAX_W+x], frame[y*MAX_W+x+1]);
            end
            repeat (2) drive(1'b1, 1'b0, 1'b1, 8'h00, 8'h00);
        end
        drive(1'b0, 1'b0, 1'b1, 8'h00, 8'h00);
        fall_cycle = cycle_cnt;
    endtask

    // ------------------------------
    // Reference model and checks
    // ------------------------------

    task automatic build_expected(input pixel_t frame [0:NPIX-1], input int w, input int h,
                                  input pixel_t thr);
        int s;
        int sx;
        int sy;
        s  = 0;
        sx = 0;
        sy = 0;
        for (int y = 0; y < h; y++) begin
            for (int x = 0; x < w; x++) begin
                if (frame[y*MAX_W+x] < thr) begin
                    s++;
                    sx += x;
                    sy += y;
                end
            end
        end
        exp_sums.sum_s  = sum_s_t'(s);
        exp_sums.sum_sx = sum_sx_t'(sx);
        exp_sums.sum_sy = sum_sy_t'(sy);
        exp_rec[0] = `RECORD_MARK;
        exp_rec[1] = exp_seq;
        for (int i = 0; i < 3; i++)
            exp_rec[2+i] = byte_t'(s >> (8 * (2 - i)));
        for (int i = 0; i < 4; i++) begin
            exp_rec[5+i] = byte_t'(sx >> (8 * (3 - i)));
            exp_rec[9+i] = byte_t'(sy >> (8 * (3 - i)));
        end
    endtask

    task automatic check_byte(input string name, input byte_t got, input byte_t exp);
        if (got !== exp) begin
            $display("CHECK FAILED %s got 0x%02h expected 0x%02h", name, got, exp);
            value_errors++;
        end
    endtask

    task automatic check_sums(input frame_sums_t got, input frame_sums_t exp);
        if (got.sum_s !== exp.sum_s) begin
            $display("CHECK FAILED sum_s got 0x%05h expected 0x%05h", got.sum_s, exp.sum_s);
            value_errors++;
        end
        if (got.sum_sx !== exp.sum_sx) begin
            $display("CHECK FAILED sum_sx got 0x%07h expected 0x%07h", got.sum_sx, exp.sum_sx);
            value_errors++;
        end
        if (got.sum_sy !== exp.sum_sy) begin
            $display("CHECK FAILED sum_sy got 0x%07h expected 0x%07h", got.sum_sy, exp.sum_sy);
            value_errors++;
        end
    endtask

    // Outputs sampled on the falling edge away from DUT updates
    task automatic collect_record(output frame_sums_t got);
        int wait_cnt;
        wait_cnt = 0;
        got      = '0;
        @(negedge cclk);
        while (!tx_valid && wait_cnt < TIMEOUT) begin
            @(negedge cclk);
            wait_cnt++;
        end
        if (!tx_valid) begin
            $display("ERROR: no record started within %0d cycles", TIMEOUT);
            other_errors++;
            return;
        end
        for (int i = 0; i < `RECORD_BYTES; i++) begin
            if (i > 0)
                @(negedge cclk);
            if (!tx_valid) begin
                $display("ERROR: tx_valid dropped at byte %0d of the record", i);
                other_errors++;
            end
            got_rec[i] = tx_byte;
            check_byte($sformatf("tx_byte[%0d]", i), tx_byte, exp_rec[i]);
        end
        if (cycle_cnt - fall_cycle != 16) begin
            $display("ERROR: last byte came %0d cycles after fval fell instead of 16",
                     cycle_cnt - fall_cycle);
            other_errors++;
        end
        got.sum_s  = sum_s_t'({got_rec[2], got_rec[3], got_rec[4]});
        got.sum_sx = sum_sx_t'({got_rec[5], got_rec[6], got_rec[7], got_rec[8]});
        got.sum_sy = sum_sy_t'({got_rec[9], got_rec[10], got_rec[11], got_rec[12]});
        exp_seq = exp_seq + seq_t'(1);
    endtask

    task automatic run_frame(input int w, input int h, input pixel_t thr, input bit gaps);
        frame_sums_t got;
        build_expected(img, w, h, thr);
        send_frame(img, w, h, thr, gaps);
        collect_record(got);
        check_sums(got, exp_sums);
    endtask

    // ------------------------------
    // Directed tests
    // ------------------------------

    task automatic test_idle();
        for (int i = 0; i < 40; i++) begin
            @(negedge cclk);
            if (tx_valid !== 1'b0) begin
                $display("ERROR: tx_valid high with no frame driven");
                other_errors++;
            end
        end
    endtask

    task automatic test_bright();
        for (int i = 0; i < NPIX; i++)
            img[i] = 8'hFF;
        run_frame(8, 4, 8'h80, 1'b0);
    endtask

    // Dark pixel at x=5, y=3 sits on the right tap
    task automatic test_right_tap();
        frame_sums_t known;
        known = '{sum_s: 1, sum_sx: 5, sum_sy: 3};
        for (int i = 0; i < NPIX; i++)
            img[i] = 8'hFF;
        img[3*MAX_W+5] = 8'h10;
        build_expected(img, 8, 4, 8'h80);
        check_sums(exp_sums, known);
        run_frame(8, 4, 8'h80, 1'b0);
    endtask

    task automatic test_dval_gaps();
        for (int i = 0; i < NPIX; i++)
            img[i] = pixel_t'(lcg_next());
        run_frame(12, 5, 8'h60, 1'b0);
        run_frame(12, 5, 8'h60, 1'b1);
    endtask

    task automatic test_random();
        for (int f = 0; f < 4; f++) begin
            for (int i = 0; i < NPIX; i++)
                img[i] = pixel_t'(lcg_next());
            run_frame(MAX_W, 6, pixel_t'(lcg_next()), f[0]);
        end
    endtask

    initial begin
        rst_n        = 1'b0;
        fval         = 1'b0;
        lval         = 1'b0;
        dval         = 1'b1;
        data_l       = 8'h00;
        data_r       = 8'h00;
        threshold    = 8'h80;
        lcg_state    = 6793;
        value_errors = 0;
        other_errors = 0;
        exp_seq      = '0;
        repeat (5) @(posedge cclk);
        #10;
        rst_n = 1'b1;

        test_idle();
        test_bright();
        test_right_tap();
        test_dval_gaps();
        test_random();

        $display("Error count: %0d value mismatches, %0d other failures",
                 value_errors, other_errors);
        if (value_errors + other_errors == 0)
            $display("Finished with no errors");
        else
            $display("Finished with errors");
        $finish;
    end

endmodule

`default_nettype wire

// ==== flist.f ====
+incdir+verilog
verilog/cl_pkg.sv
verilog/track_pkg.sv
verilog/pix_stream_if.sv
verilog/cl_frame_capture.sv
verilog/centroid_accum.sv
verilog/result_framer.sv
verilog/eye_tracker_top.sv
verif/eye_tracker_asserts.sv
verif/tb_eye_tracker.sv

// ==== Makefile ====
TOP := tb_eye_tracker

.PHONY: all run lint clean

all: run

obj_dir/V$(TOP): flist.f $(wildcard verilog/*.sv verilog/*.svh verif/*.sv)
	verilator --binary --timing --assert --timescale 1ns/100ps -f flist.f \
		--top-module $(TOP) -Mdir obj_dir

run: obj_dir/V$(TOP)
	./obj_dir/V$(TOP) > sim.log 2>&1 || true
	cat sim.log
	@if grep -q "Finished with errors" sim.log; then exit 1; fi
	@grep -q "Finished with no errors" sim.log

lint:
	verilator --lint-only -Wall --timing --timescale 1ns/100ps -f flist.f --top-module $(TOP)

clean:
	rm -rf obj_dir sim.log
